//--- Makefile
# Verilator flow for the PRBS31 tester
TOP = prbs_tester_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f files.f

# assertion errors do not stop the run, the testbench reports them at the end
run: build
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
	@cat sim.log
	@if grep -q '>>> FAIL' sim.log; then echo "simulation failed"; exit 1; fi
	@if grep -q 'simulator exited with an error' sim.log; then exit 1; fi

lint:
	verilator --lint-only -Wall --timing --top-module prbs_tester -f files.f

clean:
	rm -rf obj_dir sim.log

//--- files.f
verilog/prbs_pkg.sv
verilog/tester_pkg.sv
verilog/lfsr_step.sv
verilog/prbs_gen.sv
verilog/prbs_check.sv
verilog/lock_timer.sv
verilog/tester_fsm.sv
verilog/prbs_tester.sv
testbench/prbs_tester_checker.sv
testbench/prbs_tester_tb.sv

//--- testbench/prbs_tester_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// concurrent assertions on the tester FSM and outputs
// bound into prbs_tester by the testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module prbs_tester_checker import tester_pkg::*; (
    input wire             clk,
    input wire             rst_n,
    input wire tester_state_t state,
    input wire             tx_valid,
    input wire             chk_clear,
    input wire err_count_t err_count
);

    // failures so far, collected by the testbench at the end
    int unsigned assert_fails = 0;

    // pattern is silent while idle
    a_idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        state == ST_IDLE |-> !tx_valid)
        else begin
            $error("tx_valid high in ST_IDLE");
            assert_fails++;
        end

    // lock always goes through hunt
    a_no_skip_hunt: assert property (@(posedge clk) disable iff (!rst_n)
        state == ST_IDLE |=> state != ST_LOCKED)
        else begin
            $error("state went from ST_IDLE straight to ST_LOCKED");
            assert_fails++;
        end

    // count only drops right after a clear
    a_count_no_drop: assert property (@(posedge clk) disable iff (!rst_n)
        err_count < $past(err_count) |-> $past(chk_clear))
        else begin
            $error("err_count fell without chk_clear");
            assert_fails++;
        end

endmodule

`default_nettype wire

//--- testbench/prbs_tester_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed testbench for the PRBS31 tester
// tx loops back to rx through a flip mask
// tx words are checked against a serial bit-by-bit PRBS31 model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module prbs_tester_tb import prbs_pkg::*, tester_pkg::*; ();

    localparam int DATA_WIDTH   = 32;
    localparam int LOCK_WORDS   = 4;
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 8;
    localparam int MODEL_WORDS  = 200;
    localparam int CLEAN_WORDS  = 500;
    localparam int INJECT_COUNT = 5;
    localparam int FLIP_COUNT   = 6;
    localparam int ERR_SPACING  = 8;
    localparam int RANDOM_WORDS = 100;
    localparam int LOCK_TIMEOUT = 64;
    // every wait counted at its limit
    localparam int TEST_CYCLES = RESET_CYCLES + MODEL_WORDS + 4 * LOCK_TIMEOUT + CLEAN_WORDS
        + (INJECT_COUNT + FLIP_COUNT + 4) * ERR_SPACING + RANDOM_WORDS + 40;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + TEST_CYCLES / 4;

    typedef logic [DATA_WIDTH-1:0] word_t;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       start;
    logic       stop;
    logic       inject_err;
    word_t      rx_data = '0;
    logic       rx_valid = 1'b0;
    word_t      tx_data;
    logic       tx_valid;
    logic       locked;
    err_count_t err_count;

    // loopback controls that the tests write right on the clock edge
    logic  loop_en;
    word_t flip_mask;
    word_t rand_word;

    prbs_state_t model_state;
    int errors;
    int tests_run;
    int tests_failed;

    always #(CLK_PERIOD / 2) clk = ~clk;

    prbs_tester #(
        .DATA_WIDTH(DATA_WIDTH),
        .LOCK_WORDS(LOCK_WORDS)
    ) prbs_tester_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .stop      (stop),
        .inject_err(inject_err),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .tx_data   (tx_data),
        .tx_valid  (tx_valid),
        .locked    (locked),
        .err_count (err_count)
    );

    bind prbs_tester prbs_tester_checker chk_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .state    (fsm_i.state_q),
        .tx_valid (tx_valid),
        .chk_clear(chk_clear),
        .err_count(err_count)
    );

    // rx follows tx in the same cycle or takes random words with loop off
    always @(posedge clk) begin
        #1;
        if (loop_en) begin
            rx_data  = tx_data ^ flip_mask;
            rx_valid = tx_valid;
        end else begin
            rx_data  = rand_word;
            rx_valid = 1'b1;
        end
    end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // serial x^31 + x^28 + 1 model with the earliest bit in the MSB
    task automatic model_word(output word_t word);
        logic fb;
        int   b;
        word = '0;
        for (b = DATA_WIDTH - 1; b >= 0; b--) begin
            fb = model_state[30] ^ model_state[27];
            model_state = {model_state[29:0], fb};
            word[b] = fb;
        end
    endtask

    task automatic start_pulse();
        start = 1'b1;
        tick();
        start = 1'b0;
    endtask

    task automatic wait_locked(output bit ok);
        int n;
        n = 0;
        while (!locked && n < LOCK_TIMEOUT) begin
            tick();
            n++;
        end
        ok = locked;
        if (!ok) begin
            $display("locked did not rise within %0d cycles", LOCK_TIMEOUT);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d check(s) failed", tests_run, name, errors - errs_before);
        end
    endtask

    task automatic reset_values();
        int e0;
        e0 = errors;
        if (tx_valid !== 1'b0) begin
            $display("Error: tx_valid = %h, expected %h", tx_valid, 1'b0);
            errors++;
        end
        if (locked !== 1'b0) begin
            $display("Error: locked = %h, expected %h", locked, 1'b0);
            errors++;
        end
        if (err_count !== '0) begin
            $display("Error: err_count = %h, expected %h", err_count, err_count_t'(0));
            errors++;
        end
        report_test("reset values", e0);
    endtask

    task automatic pattern_vs_model();
        int    e0;
        int    n;
        int    w;
        word_t exp;
        e0 = errors;
        model_state = PRBS_SEED;
        start_pulse();
        n = 0;
        while (!tx_valid && n < LOCK_TIMEOUT) begin
            tick();
            n++;
        end
        if (!tx_valid) begin
            $display("tx_valid never rose after start");
            errors++;
        end else begin
            for (w = 0; w < MODEL_WORDS; w++) begin
                model_word(exp);
                if (tx_valid !== 1'b1 || tx_data !== exp) begin
                    $display("Error: tx_data = %h, expected %h (tx_valid %h, word %0d)",
                             tx_data, exp, tx_valid, w);
                    errors++;
                end
                tick();
            end
        end
        report_test("pattern vs model", e0);
    endtask

    task automatic clean_loopback_lock();
        int e0;
        int w;
        bit ok;
        bit bad;
        e0 = errors;
        bad = 1'b0;
        start_pulse();
        wait_locked(ok);
        if (ok) begin
            for (w = 0; w < CLEAN_WORDS && !bad; w++) begin
                tick();
                if (err_count !== '0) begin
                    $display("Error: err_count = %h, expected %h after %0d clean words",
                             err_count, err_count_t'(0), w);
                    errors++;
                    bad = 1'b1;
                end
            end
            if (locked !== 1'b1) begin
                $display("Error: locked = %h, expected %h", locked, 1'b1);
                errors++;
            end
        end
        report_test("clean loopback lock", e0);
    endtask

    task automatic inject_err_count();
        int e0;
        int k;
        bit ok;
        e0 = errors;
        start_pulse();
        wait_locked(ok);
        if (ok) begin
            for (k = 0; k < INJECT_COUNT; k++) begin
                inject_err = 1'b1;
                tick();
                inject_err = 1'b0;
                repeat (ERR_SPACING - 1) tick();
            end
            // tap errors trail the flipped bit by up to two words
            repeat (ERR_SPACING) tick();
            if (err_count !== err_count_t'(3 * INJECT_COUNT)) begin
                $display("Error: err_count = %h, expected %h", err_count,
                         err_count_t'(3 * INJECT_COUNT));
                errors++;
            end
        end
        report_test("inject_err count", e0);
    endtask

    task automatic line_flips_and_stop();
        int         e0;
        int         k;
        int         pos;
        bit         ok;
        err_count_t held;
        e0 = errors;
        start_pulse();
        wait_locked(ok);
        if (ok) begin
            for (k = 0; k < FLIP_COUNT; k++) begin
                pos = $urandom % DATA_WIDTH;
                // loopback picks the mask up 1 unit after this edge
                @(posedge clk);
                flip_mask = word_t'(1) << pos;
                @(posedge clk);
                flip_mask = '0;
                #1;
                repeat (ERR_SPACING - 2) tick();
            end
            repeat (ERR_SPACING) tick();
            if (err_count !== err_count_t'(3 * FLIP_COUNT)) begin
                $display("Error: err_count = %h, expected %h", err_count,
                         err_count_t'(3 * FLIP_COUNT));
                errors++;
            end
            held = err_count;
            stop = 1'b1;
            tick();
            stop = 1'b0;
            if (tx_valid !== 1'b0) begin
                $display("Error: tx_valid = %h, expected %h after stop", tx_valid, 1'b0);
                errors++;
            end
            // valid line noise while stopped must not reach the count
            repeat (4) begin
                @(posedge clk);
                loop_en = 1'b0;
                rand_word = $urandom;
                #1;
            end
            if (err_count !== held) begin
                $display("Error: err_count = %h, expected %h while stopped", err_count, held);
                errors++;
            end
            // restart clears the count
            start_pulse();
            if (err_count !== '0) begin
                $display("Error: err_count = %h, expected %h after start", err_count,
                         err_count_t'(0));
                errors++;
            end
        end
        report_test("line flips and stop", e0);
    endtask

    task automatic random_rx_no_lock();
        int e0;
        int w;
        bit bad;
        e0 = errors;
        bad = 1'b0;
        @(posedge clk);
        loop_en = 1'b0;
        rand_word = $urandom;
        #1;
        start_pulse();
        for (w = 0; w < RANDOM_WORDS && !bad; w++) begin
            if (locked !== 1'b0) begin
                $display("Error: locked = %h, expected %h on random word %0d", locked, 1'b0, w);
                errors++;
                bad = 1'b1;
            end
            @(posedge clk);
            rand_word = $urandom;
            #1;
        end
        report_test("random rx no lock", e0);
    endtask

    initial begin
        int unsigned assert_errs;
        void'($urandom(24));
        rst_n = 1'b0;
        start = 1'b0;
        stop = 1'b0;
        inject_err = 1'b0;
        loop_en = 1'b1;
        flip_mask = '0;
        rand_word = '0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        reset_values();
        pattern_vs_model();
        clean_loopback_lock();
        inject_err_count();
        line_flips_and_stop();
        random_rx_no_lock();
        assert_errs = prbs_tester_i.chk_i.assert_fails;
        $display("tests run %0d, tests failed %0d, check errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, assert_errs);
        if (errors == 0 && assert_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // bound on the whole run
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/lfsr_step.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// unrolled PRBS31 step, DATA_WIDTH shifts per pass, purely combinational
// FEED_FORWARD=0 generates (tie data_in low), FEED_FORWARD=1 checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module lfsr_step import prbs_pkg::*; #(
    parameter int DATA_WIDTH = 32,
    parameter bit FEED_FORWARD = 1'b0
) (
    input  wire [DATA_WIDTH-1:0] data_in,
    input  wire prbs_state_t     state_in,
    output logic [DATA_WIDTH-1:0] data_out,
    output prbs_state_t          state_out
);

    // masks select from {data_in, state_in}, state in the low bits
    localparam int MASK_WIDTH = PRBS_WIDTH + DATA_WIDTH;

    typedef logic [MASK_WIDTH-1:0] mask_t;

    // index below PRBS_WIDTH selects a state bit, above it a data bit
    function automatic mask_t step_mask(input int index);
        mask_t reg_mask [PRBS_WIDTH];
        mask_t out_mask [DATA_WIDTH];
        mask_t in_bit;
        mask_t fb;
        int i;
        int b;
        // each register bit starts as itself
        for (i = 0; i < PRBS_WIDTH; i++) begin
            reg_mask[i] = mask_t'(1) << i;
        end
        for (i = 0; i < DATA_WIDTH; i++) begin
            out_mask[i] = '0;
        end
        // MSB of the word goes first
        for (b = DATA_WIDTH - 1; b >= 0; b--) begin
            in_bit = mask_t'(1) << (PRBS_WIDTH + b);
            // taps at x^31 and x^28
            fb = reg_mask[PRBS_WIDTH-1] ^ reg_mask[PRBS_TAP-1] ^ in_bit;
            for (i = DATA_WIDTH - 1; i > 0; i--) begin
                out_mask[i] = out_mask[i-1];
            end
            out_mask[0] = fb;
            for (i = PRBS_WIDTH - 1; i > 0; i--) begin
                reg_mask[i] = reg_mask[i-1];
            end
            // checker keeps raw line bits as its history
            reg_mask[0] = FEED_FORWARD ? in_bit : fb;
        end
        if (index < PRBS_WIDTH) begin
            return reg_mask[index];
        end
        return out_mask[index-PRBS_WIDTH];
    endfunction

    for (genvar n = 0; n < PRBS_WIDTH; n++) begin : g_state
        localparam mask_t STATE_MASK = step_mask(n);
        assign state_out[n] = ^({data_in, state_in} & STATE_MASK);
    end

    // in feed-forward form these are the prediction errors
    for (genvar n = 0; n < DATA_WIDTH; n++) begin : g_data
        localparam mask_t DATA_MASK = step_mask(PRBS_WIDTH + n);
        assign data_out[n] = ^({data_in, state_in} & DATA_MASK);
    end

endmodule

`default_nettype wire

//--- verilog/lock_timer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// counts consecutive clean words from the checker
// lock_reached rises at LOCK_WORDS and holds until clear
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module lock_timer import tester_pkg::*; #(
    parameter int LOCK_WORDS = 4
) (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  clear,
    input  wire  word_valid,
    input  wire  word_clean,
    output logic lock_reached
);

    lock_count_t clean_cnt;
    logic        valid_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q      <= 1'b0;
            clean_cnt    <= '0;
            lock_reached <= 1'b0;
        end else if (clear) begin
            valid_q      <= 1'b0;
            clean_cnt    <= '0;
            lock_reached <= 1'b0;
        end else begin
            // checker result lags rx_valid by one cycle
            valid_q <= word_valid;
            if (valid_q && !word_clean) begin
                clean_cnt <= '0;
            end else if (word_clean && clean_cnt != lock_count_t'(LOCK_WORDS)) begin
                clean_cnt <= clean_cnt + 1'b1;
                if (clean_cnt == lock_count_t'(LOCK_WORDS - 1)) begin
                    lock_reached <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/prbs_check.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// self-synchronising PRBS31 checker on received words
// flags clean words and accumulates error bits while count_en is high
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module prbs_check import prbs_pkg::*, tester_pkg::*; #(
    parameter int DATA_WIDTH = 32
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire [DATA_WIDTH-1:0] rx_data,
    input  wire                  rx_valid,
    input  wire                  chk_clear,
    input  wire                  count_en,
    output logic                 word_clean,
    output err_count_t           err_count
);

    localparam err_count_t ERR_MAX = '1;

    prbs_state_t                 hist_q;
    prbs_state_t                 hist_next;
    logic [DATA_WIDTH-1:0]       err_bits;
    pop_count_t                  err_pop;
    logic [$bits(err_count_t):0] err_sum;

    // history is the last 31 line bits, predictions come from it
    lfsr_step #(
        .DATA_WIDTH  (DATA_WIDTH),
        .FEED_FORWARD(1'b1)
    ) step_i (
        .data_in  (rx_data),
        .state_in (hist_q),
        .data_out (err_bits),
        .state_out(hist_next)
    );

    // count the error bits in this word
    always_comb begin
        err_pop = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            err_pop = err_pop + pop_count_t'(err_bits[i]);
        end
    end

    // one extra bit catches the overflow
    assign err_sum = {1'b0, err_count} + ($bits(err_sum))'(err_pop);

    always_ff @(posedge clk) begin
        if (chk_clear) begin
            hist_q <= '0;
        end else if (rx_valid) begin
            hist_q <= hist_next;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_clean <= 1'b0;
            err_count  <= '0;
        end else begin
            word_clean <= rx_valid & ~chk_clear & (err_pop == '0);
            if (chk_clear) begin
                err_count <= '0;
            end else if (rx_valid && count_en) begin
                // saturate rather than wrap
                err_count <= err_sum[$bits(err_count_t)] ? ERR_MAX
                                                         : err_sum[$bits(err_count_t)-1:0];
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/prbs_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PRBS31 word generator, one word per enabled cycle
// seed_load restarts the sequence, inject_err corrupts bit 0 once
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module prbs_gen import prbs_pkg::*; #(
    parameter int DATA_WIDTH = 32
) (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   gen_en,
    input  wire                   seed_load,
    input  wire                   inject_err,
    output logic [DATA_WIDTH-1:0] tx_data,
    output logic                  tx_valid
);

    typedef logic [DATA_WIDTH-1:0] word_t;

    prbs_state_t state_q;
    prbs_state_t state_cur;
    prbs_state_t state_next;
    word_t       word_next;
    word_t       word_q;
    logic        inject_q;

    // seed feeds straight into the step so the first word is not delayed
    assign state_cur = seed_load ? PRBS_SEED : state_q;

    lfsr_step #(
        .DATA_WIDTH  (DATA_WIDTH),
        .FEED_FORWARD(1'b0)
    ) step_i (
        .data_in  (word_t'(0)),
        .state_in (state_cur),
        .data_out (word_next),
        .state_out(state_next)
    );

    always_ff @(posedge clk) begin
        if (gen_en) begin
            state_q <= state_next;
            word_q  <= word_next;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_valid <= 1'b0;
            inject_q <= 1'b0;
        end else begin
            tx_valid <= gen_en;
            // pending flip, applies to the word going out next cycle
            inject_q <= inject_err & gen_en;
        end
    end

    assign tx_data = word_q ^ word_t'(inject_q);

endmodule

`default_nettype wire

//--- verilog/prbs_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pattern definitions for the PRBS31 tester
// import into any block that touches the LFSR state or pattern widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package prbs_pkg;

    // x^31 + x^28 + 1, Fibonacci form
    localparam int PRBS_WIDTH = 31;
    // inner tap, the outer one is the register length itself
    localparam int PRBS_TAP = 28;

    // widest word the step logic is sized for
    localparam int MAX_DATA_WIDTH = 64;

    // shift register contents, bit 0 holds the newest bit
    typedef logic [PRBS_WIDTH-1:0] prbs_state_t;

    // any nonzero value would do, all ones is the usual choice
    localparam prbs_state_t PRBS_SEED = '1;

    // number of error bits in one word, up to MAX_DATA_WIDTH
    typedef logic [$clog2(MAX_DATA_WIDTH+1)-1:0] pop_count_t;

endpackage

`default_nettype wire

//--- verilog/prbs_tester.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PRBS31 link tester top level
// tx side drives the pattern, rx side checks it and counts bit errors
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module prbs_tester import tester_pkg::*; #(
    parameter int DATA_WIDTH = 32,
    parameter int LOCK_WORDS = 4
) (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   start,
    input  wire                   stop,
    input  wire                   inject_err,
    input  wire [DATA_WIDTH-1:0]  rx_data,
    input  wire                   rx_valid,
    output logic [DATA_WIDTH-1:0] tx_data,
    output logic                  tx_valid,
    output logic                  locked,
    output err_count_t            err_count
);

    // control from the FSM
    logic gen_en;
    logic seed_load;
    logic chk_clear;
    logic count_en;
    logic inject;

    // status back to the FSM
    logic word_clean;
    logic lock_reached;

    tester_fsm fsm_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .stop        (stop),
        .inject_err  (inject_err),
        .lock_reached(lock_reached),
        .gen_en      (gen_en),
        .seed_load   (seed_load),
        .chk_clear   (chk_clear),
        .count_en    (count_en),
        .locked      (locked),
        .inject      (inject)
    );

    prbs_gen #(
        .DATA_WIDTH(DATA_WIDTH)
    ) gen_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .gen_en    (gen_en),
        .seed_load (seed_load),
        .inject_err(inject),
        .tx_data   (tx_data),
        .tx_valid  (tx_valid)
    );

    prbs_check #(
        .DATA_WIDTH(DATA_WIDTH)
    ) check_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .chk_clear (chk_clear),
        .count_en  (count_en),
        .word_clean(word_clean),
        .err_count (err_count)
    );

    // cleared together with the checker on start
    lock_timer #(
        .LOCK_WORDS(LOCK_WORDS)
    ) timer_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .clear       (chk_clear),
        .word_valid  (rx_valid),
        .word_clean  (word_clean),
        .lock_reached(lock_reached)
    );

endmodule

`default_nettype wire

//--- verilog/tester_fsm.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tester control FSM, idle / hunt / locked
// turns the start, stop and inject strobes into generator and checker controls
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module tester_fsm import tester_pkg::*; (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  start,
    input  wire  stop,
    input  wire  inject_err,
    input  wire  lock_reached,
    output logic gen_en,
    output logic seed_load,
    output logic chk_clear,
    output logic count_en,
    output logic locked,
    output logic inject
);

    tester_state_t state_q;
    tester_state_t state_d;
    logic          running;
    logic          restart;

    assign running = (state_q != ST_IDLE);
    // stop beats start
    assign restart = start & ~stop;

    always_comb begin
        state_d = state_q;
        if (stop) begin
            state_d = ST_IDLE;
        end else if (start) begin
            // start from any state reseeds and hunts again
            state_d = ST_HUNT;
        end else if (state_q == ST_HUNT && lock_reached) begin
            state_d = ST_LOCKED;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // generator steps on the start cycle too, first word one cycle later
    assign gen_en    = (start | running) & ~stop;
    assign seed_load = restart;
    assign chk_clear = restart;

    assign count_en = (state_q == ST_LOCKED);
    assign locked   = (state_q == ST_LOCKED);

    // errors only go into a running pattern
    assign inject = inject_err & running & ~stop;

endmodule

`default_nettype wire

//--- verilog/tester_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// control definitions for the tester
// state encoding and counter widths shared by FSM, timer and checker
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package tester_pkg;

    // idle until start, hunt for lock, then count errors
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HUNT,
        ST_LOCKED
    } tester_state_t;

    // accumulated error bits, sticks at all ones
    typedef logic [15:0] err_count_t;

    // consecutive clean words seen while hunting
    typedef logic [7:0] lock_count_t;

endpackage

`default_nettype wire
